// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    localparam int DEF_STEP_W = 3;  // Enough for the longest kept sequence

    typedef enum logic [3:0] {
        NONE = 4'd0,
        Z    = 4'd1,
        W    = 4'd2,
        B    = 4'd3,
        C    = 4'd4,
        D    = 4'd5,
        E    = 4'd6,
        H    = 4'd7,
        L    = 4'd8,
        SPH  = 4'd9,
        SPL  = 4'd10,
        PCH  = 4'd11,
        PCL  = 4'd12,
        A    = 4'd13,
        F    = 4'd14,
        MEM  = 4'd15                // Data bus side of the memory port
    } reg8_t;

    typedef enum logic [2:0] {
        WZ, BC, DE, HL, AF, SP, PC
    } reg16_t;

    typedef enum logic {
        AB_NO_MASK,
        AB_MASK_AND_FF00            // Keeps only the high byte of the address
    } ab_mask_t;

    typedef enum logic [2:0] {
        ADD, ADC, SUB, SBC, AND, XOR, OR, CP
    } alu_op_t;

    typedef enum logic [1:0] {
        COND_NZ, COND_Z, COND_NC, COND_C
    } cond_t;

    typedef struct packed {
        logic f_z;
        logic f_n;
        logic f_h;
        logic f_c;
    } flags_t;

    typedef enum logic [2:0] {
        ACC_A   = 3'd0,
        ACC_DB  = 3'd1,
        ACC_PCL = 3'd4
    } s_acc_t;

    typedef enum logic {
        ARG_DB, ARG_ONE
    } s_arg_t;

    typedef enum logic {
        R_WB_DB, R_WB_ALU
    } s_r_wb_t;

    typedef enum logic [1:0] {
        RR_WB_NONE, RR_WB_IDU, RR_WB_WZ
    } s_rr_wb_t;

    typedef enum logic [1:0] {
        INC, DEC, ADJ               // ADJ carries the PCL offset into the high byte
    } idu_mode_t;

    typedef enum logic [3:0] {
        OP_NOP, OP_LD_R_R, OP_LD_R_N, OP_LD_HL_N, OP_LD_R_HL, OP_LD_HL_R,
        OP_ALU_R, OP_ALU_HL, OP_ALU_N, OP_INCDEC_R, OP_JR, OP_JR_CC
    } op_class_t;

endpackage

// ==== step_if.sv ====
interface step_if #(
    parameter int STEP_W = 3
);
    logic [STEP_W-1:0] step;        // Current microcode step
    logic              done;        // Last step of the instruction
    logic              is_cond;     // Branch on condition instead of incrementing
    logic [STEP_W-1:0] next_cond;   // Step taken when the condition fails

    modport sequencer (
        output step,
        input  done,
        input  is_cond,
        input  next_cond
    );

    modport ucode (
        input  step,
        output done,
        output is_cond,
        output next_cond
    );

endinterface

// ==== field_if.sv ====
interface field_if;
    import cpu_ctrl_pkg::*;

    op_class_t op_class;
    reg8_t     r8_dst;              // From opcode bits 5..3
    reg8_t     r8_src;              // From opcode bits 2..0
    alu_op_t   alu_op;

    modport source (
        output op_class, r8_dst, r8_src, alu_op
    );

    modport sink (
        input op_class, r8_dst, r8_src, alu_op
    );

endinterface

// ==== op_fields.sv ====
module op_fields (
    input  logic [7:0] ir,
    field_if.source    fields
);
    import cpu_ctrl_pkg::*;

    op_class_t cls;

    function automatic reg8_t r8_decode(input logic [2:0] code);
        case (code)
            3'd0: return B;
            3'd1: return C;
            3'd2: return D;
            3'd3: return E;
            3'd4: return H;
            3'd5: return L;
            3'd6: return MEM;           // [HL]
            default: return A;
        endcase
    endfunction

    // First match wins, so the specific patterns sit above the general ones
    always_comb begin
        casez (ir)
            8'h00:       cls = OP_NOP;
            8'h18:       cls = OP_JR;
            8'b001??000: cls = OP_JR_CC;
            8'h36:       cls = OP_LD_HL_N;
            8'b00???110: cls = OP_LD_R_N;
            8'b0011010?: cls = OP_NOP;      // INC/DEC [HL] not supported
            8'b00???10?: cls = OP_INCDEC_R;
            8'h76:       cls = OP_NOP;      // HALT slot
            8'b01110???: cls = OP_LD_HL_R;
            8'b01???110: cls = OP_LD_R_HL;
            8'b01??????: cls = OP_LD_R_R;
            8'b10???110: cls = OP_ALU_HL;
            8'b10??????: cls = OP_ALU_R;
            8'b11???110: cls = OP_ALU_N;
            default:     cls = OP_NOP;
        endcase
    end

    always_comb begin
        fields.op_class = cls;
        fields.r8_dst = r8_decode(ir[5:3]);
        fields.r8_src = r8_decode(ir[2:0]);
        case (cls)
            OP_ALU_R, OP_ALU_HL, OP_ALU_N: fields.alu_op = alu_op_t'(ir[5:3]);
            OP_INCDEC_R: fields.alu_op = ir[0] ? SUB : ADD;   // Bit 0 selects DEC
            default: fields.alu_op = ADD;
        endcase
    end

endmodule

// ==== step_sequencer.sv ====
module step_sequencer #(
    parameter int STEP_W = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           d_in,
    input  cpu_ctrl_pkg::flags_t flags,
    output logic [7:0]           ir,
    step_if.sequencer            seq
);
    import cpu_ctrl_pkg::*;

    cond_t cond;
    logic  cond_met;

    assign cond = cond_t'(ir[4:3]);     // cc field of JR cc,e

    always_comb begin
        case (cond)
            COND_NZ: cond_met = !flags.f_z;
            COND_Z:  cond_met = flags.f_z;
            COND_NC: cond_met = !flags.f_c;
            default: cond_met = flags.f_c;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ir <= 8'h00;                    // Starts on a NOP, which fetches
            seq.step <= '0;
        end else if (seq.done) begin
            ir <= d_in;                     // Opcode fetched in the last step
            seq.step <= '0;
        end else if (seq.is_cond && !cond_met) begin
            seq.step <= seq.next_cond;      // Skip the branch body
        end else begin
            seq.step <= seq.step + 1'b1;
        end
    end

endmodule

// ==== ucode_table.sv ====
module ucode_table #(
    parameter int STEP_W = 3
) (
    field_if.sink                     fields,
    step_if.ucode                     seq,
    output cpu_ctrl_pkg::reg16_t      s_ab,
    output cpu_ctrl_pkg::ab_mask_t    ab_mask,
    output cpu_ctrl_pkg::reg8_t       s_db,
    output cpu_ctrl_pkg::reg8_t       t_db,
    output cpu_ctrl_pkg::s_r_wb_t     s_r_wb,
    output cpu_ctrl_pkg::alu_op_t     alu_op,
    output cpu_ctrl_pkg::s_acc_t      s_acc,
    output cpu_ctrl_pkg::s_arg_t      s_arg,
    output cpu_ctrl_pkg::idu_mode_t   idu,
    output cpu_ctrl_pkg::s_rr_wb_t    s_rr_wb,
    output cpu_ctrl_pkg::reg16_t      t_rr_wb,
    output logic                      wr_pc
);
    import cpu_ctrl_pkg::*;

    logic fetch;    // Fetch next opcode at the address bus and finish
    logic imm;      // Read the byte at PC into Z and advance PC

    always_comb begin
        fetch = 1'b0;
        imm = 1'b0;
        seq.done = 1'b0;
        seq.is_cond = 1'b0;
        seq.next_cond = '0;
        wr_pc = 1'b0;
        s_ab = PC;
        ab_mask = AB_NO_MASK;
        s_db = NONE;
        t_db = NONE;
        s_r_wb = R_WB_DB;
        alu_op = fields.alu_op;
        s_acc = ACC_A;
        s_arg = ARG_DB;
        idu = INC;
        s_rr_wb = RR_WB_NONE;
        t_rr_wb = WZ;

        case (fields.op_class)
            OP_LD_R_R: begin
                fetch = 1'b1;
                if (seq.step == STEP_W'(0)) begin
                    s_db = fields.r8_src;
                    t_db = fields.r8_dst;
                end
            end
            OP_LD_R_N: begin
                if (seq.step == STEP_W'(0)) begin
                    imm = 1'b1;
                end else begin
                    fetch = 1'b1;
                    if (seq.step == STEP_W'(1)) begin
                        s_db = Z;
                        t_db = fields.r8_dst;
                    end
                end
            end
            OP_LD_HL_N: begin
                case (seq.step)
                    STEP_W'(0): imm = 1'b1;
                    STEP_W'(1): begin
                        s_ab = HL;              // Store the immediate at [HL]
                        s_db = Z;
                        t_db = MEM;
                    end
                    default: fetch = 1'b1;
                endcase
            end
            OP_LD_R_HL, OP_ALU_HL, OP_ALU_N: begin
                case (seq.step)
                    STEP_W'(0): begin
                        if (fields.op_class == OP_ALU_N) begin
                            imm = 1'b1;
                        end else begin
                            s_ab = HL;          // Operand from memory into Z
                            s_db = MEM;
                            t_db = Z;
                        end
                    end
                    STEP_W'(1): begin
                        fetch = 1'b1;
                        s_db = Z;
                        if (fields.op_class == OP_LD_R_HL) begin
                            t_db = fields.r8_dst;
                        end else begin
                            t_db = A;
                            s_r_wb = R_WB_ALU;
                        end
                    end
                    default: fetch = 1'b1;
                endcase
            end
            OP_LD_HL_R: begin
                if (seq.step == STEP_W'(0)) begin
                    s_ab = HL;
                    s_db = fields.r8_src;
                    t_db = MEM;
                end else begin
                    fetch = 1'b1;
                end
            end
            OP_ALU_R: begin
                fetch = 1'b1;
                if (seq.step == STEP_W'(0)) begin
                    s_db = fields.r8_src;
                    t_db = A;
                    s_r_wb = R_WB_ALU;
                end
            end
            OP_INCDEC_R: begin
                fetch = 1'b1;
                if (seq.step == STEP_W'(0)) begin
                    s_db = fields.r8_dst;       // Register on both sides of the ALU
                    t_db = fields.r8_dst;
                    s_r_wb = R_WB_ALU;
                    s_acc = ACC_DB;
                    s_arg = ARG_ONE;
                end
            end
            OP_JR, OP_JR_CC: begin
                case (seq.step)
                    STEP_W'(0): begin
                        imm = 1'b1;
                        if (fields.op_class == OP_JR_CC) begin
                            seq.is_cond = 1'b1;
                            seq.next_cond = STEP_W'(3);
                        end
                    end
                    STEP_W'(1): begin
                        ab_mask = AB_MASK_AND_FF00;     // Z <- PCL + e, W <- adjusted PCH
                        idu = ADJ;
                        s_db = Z;
                        t_db = Z;
                        s_r_wb = R_WB_ALU;
                        alu_op = ADD;
                        s_acc = ACC_PCL;
                        s_rr_wb = RR_WB_IDU;
                        t_rr_wb = WZ;
                    end
                    STEP_W'(2): begin
                        fetch = 1'b1;
                        s_ab = WZ;                      // Fetch from the branch target
                    end
                    default: fetch = 1'b1;
                endcase
            end
            default: fetch = 1'b1;
        endcase

        if (imm) begin
            wr_pc = 1'b1;
            s_db = MEM;
            t_db = Z;
        end
        if (fetch) begin
            seq.done = 1'b1;
            wr_pc = 1'b1;
        end
    end

endmodule

// ==== cpu_ctrl.sv ====
module cpu_ctrl #(
    parameter int STEP_W = cpu_ctrl_pkg::DEF_STEP_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                d_in,
    input  cpu_ctrl_pkg::flags_t      flags,
    output logic [7:0]                ir,
    output logic [STEP_W-1:0]         step,
    output logic                      done,
    output cpu_ctrl_pkg::reg16_t      s_ab,
    output cpu_ctrl_pkg::ab_mask_t    ab_mask,
    output cpu_ctrl_pkg::reg8_t       s_db,
    output cpu_ctrl_pkg::reg8_t       t_db,
    output cpu_ctrl_pkg::s_r_wb_t     s_r_wb,
    output cpu_ctrl_pkg::alu_op_t     alu_op,
    output cpu_ctrl_pkg::s_acc_t      s_acc,
    output cpu_ctrl_pkg::s_arg_t      s_arg,
    output cpu_ctrl_pkg::idu_mode_t   idu,
    output cpu_ctrl_pkg::s_rr_wb_t    s_rr_wb,
    output cpu_ctrl_pkg::reg16_t      t_rr_wb,
    output logic                      wr_pc
);

    step_if #(.STEP_W(STEP_W)) step_bus ();
    field_if field_bus ();

    op_fields u_fields (
        .ir     (ir),
        .fields (field_bus.source)
    );

    step_sequencer #(.STEP_W(STEP_W)) u_seq (
        .clk   (clk),
        .rst   (rst),
        .d_in  (d_in),
        .flags (flags),
        .ir    (ir),
        .seq   (step_bus.sequencer)
    );

    ucode_table #(.STEP_W(STEP_W)) u_table (
        .fields  (field_bus.sink),
        .seq     (step_bus.ucode),
        .s_ab    (s_ab),
        .ab_mask (ab_mask),
        .s_db    (s_db),
        .t_db    (t_db),
        .s_r_wb  (s_r_wb),
        .alu_op  (alu_op),
        .s_acc   (s_acc),
        .s_arg   (s_arg),
        .idu     (idu),
        .s_rr_wb (s_rr_wb),
        .t_rr_wb (t_rr_wb),
        .wr_pc   (wr_pc)
    );

    assign step = step_bus.step;
    assign done = step_bus.done;    // High in the fetch cycle of every instruction

endmodule

// ==== ctrl_checker.sv ====
module ctrl_checker #(
    parameter int STEP_W = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                d_in,
    input  cpu_ctrl_pkg::flags_t      flags,
    input  logic [7:0]                ir,
    input  logic [STEP_W-1:0]         step,
    input  logic                      done,
    input  cpu_ctrl_pkg::reg16_t      s_ab,
    input  cpu_ctrl_pkg::ab_mask_t    ab_mask,
    input  cpu_ctrl_pkg::reg8_t       s_db,
    input  cpu_ctrl_pkg::reg8_t       t_db,
    input  cpu_ctrl_pkg::s_r_wb_t     s_r_wb,
    input  cpu_ctrl_pkg::alu_op_t     alu_op,
    input  cpu_ctrl_pkg::s_acc_t      s_acc,
    input  cpu_ctrl_pkg::s_arg_t      s_arg,
    input  cpu_ctrl_pkg::idu_mode_t   idu,
    input  cpu_ctrl_pkg::s_rr_wb_t    s_rr_wb,
    input  cpu_ctrl_pkg::reg16_t      t_rr_wb,
    input  logic                      wr_pc,
    output int                        errors
);
    import cpu_ctrl_pkg::*;

    typedef struct packed {
        logic      done;
        logic      wr_pc;
        reg16_t    s_ab;
        ab_mask_t  ab_mask;
        reg8_t     s_db;
        reg8_t     t_db;
        s_r_wb_t   s_r_wb;
        alu_op_t   alu_op;
        s_acc_t    s_acc;
        s_arg_t    s_arg;
        idu_mode_t idu;
        s_rr_wb_t  s_rr_wb;
        reg16_t    t_rr_wb;
    } ctrl_word_t;

    localparam reg8_t REG_MAP [0:7] = '{B, C, D, E, H, L, MEM, A};

    logic [7:0]        m_ir;            // Model of the instruction register
    logic [STEP_W-1:0] m_step;
    logic              first;           // First cycle after reset
    int                n_chk [1:6] = '{default: 0};
    int                n_err [1:6] = '{default: 0};
    string             beh_name [1:6] = '{"reset state", "ir and step update",
                                          "single-step classes", "memory and immediate",
                                          "relative jumps", "unsupported opcodes"};

    initial errors = 0;

    function automatic op_class_t classify(input logic [7:0] op);
        if (op == 8'h00) return OP_NOP;
        if (op == 8'h18) return OP_JR;
        if ((op & 8'he7) == 8'h20) return OP_JR_CC;
        if (op == 8'h36) return OP_LD_HL_N;
        if ((op & 8'hc7) == 8'h06) return OP_LD_R_N;
        if ((op & 8'hc6) == 8'h04 && op[5:3] != 3'b110) return OP_INCDEC_R;
        if (op == 8'h76) return OP_NOP;
        if ((op & 8'hf8) == 8'h70) return OP_LD_HL_R;
        if ((op & 8'hc7) == 8'h46) return OP_LD_R_HL;
        if (op[7:6] == 2'b01) return OP_LD_R_R;
        if ((op & 8'hc7) == 8'h86) return OP_ALU_HL;
        if (op[7:6] == 2'b10) return OP_ALU_R;
        if ((op & 8'hc7) == 8'hc6) return OP_ALU_N;
        return OP_NOP;
    endfunction

    function automatic logic cond_true(input logic [1:0] cc, input flags_t f);
        case (cc)
            2'b00: return !f.f_z;
            2'b01: return f.f_z;
            2'b10: return !f.f_c;
            default: return f.f_c;
        endcase
    endfunction

    function automatic ctrl_word_t expected_word(input logic [7:0] op, input int s);
        ctrl_word_t w;
        op_class_t  cls;
        reg8_t      dst;
        reg8_t      src;
        logic       fetch;
        logic       imm;
        cls = classify(op);
        dst = REG_MAP[op[5:3]];
        src = REG_MAP[op[2:0]];
        fetch = 1'b1;                   // Unlisted steps fetch
        imm = 1'b0;
        w.done = 1'b0;
        w.wr_pc = 1'b0;
        w.s_ab = PC;
        w.ab_mask = AB_NO_MASK;
        w.s_db = NONE;
        w.t_db = NONE;
        w.s_r_wb = R_WB_DB;
        w.alu_op = ADD;
        w.s_acc = ACC_A;
        w.s_arg = ARG_DB;
        w.idu = INC;
        w.s_rr_wb = RR_WB_NONE;
        w.t_rr_wb = WZ;
        if (cls == OP_ALU_R || cls == OP_ALU_HL || cls == OP_ALU_N) begin
            w.alu_op = alu_op_t'(op[5:3]);
        end
        if (cls == OP_INCDEC_R) begin
            w.alu_op = op[0] ? SUB : ADD;
        end
        case (cls)
            OP_LD_R_R, OP_ALU_R: begin
                if (s == 0) begin
                    w.s_db = src;
                    w.t_db = (cls == OP_ALU_R) ? A : dst;
                    w.s_r_wb = (cls == OP_ALU_R) ? R_WB_ALU : R_WB_DB;
                end
            end
            OP_INCDEC_R: begin
                if (s == 0) begin
                    w.s_db = dst;
                    w.t_db = dst;
                    w.s_r_wb = R_WB_ALU;
                    w.s_acc = ACC_DB;
                    w.s_arg = ARG_ONE;
                end
            end
            OP_LD_R_N, OP_ALU_N, OP_LD_HL_N, OP_LD_R_HL, OP_ALU_HL: begin
                if (s == 0) begin
                    fetch = 1'b0;
                    if (cls == OP_LD_R_HL || cls == OP_ALU_HL) begin
                        w.s_ab = HL;
                        w.s_db = MEM;
                        w.t_db = Z;
                    end else begin
                        imm = 1'b1;
                    end
                end else if (s == 1 && cls == OP_LD_HL_N) begin
                    fetch = 1'b0;
                    w.s_ab = HL;        // Immediate goes out to [HL]
                    w.s_db = Z;
                    w.t_db = MEM;
                end else if (s == 1) begin
                    w.s_db = Z;
                    w.t_db = (cls == OP_LD_R_N || cls == OP_LD_R_HL) ? dst : A;
                    if (cls == OP_ALU_N || cls == OP_ALU_HL) w.s_r_wb = R_WB_ALU;
                end
            end
            OP_LD_HL_R: begin
                if (s == 0) begin
                    fetch = 1'b0;
                    w.s_ab = HL;
                    w.s_db = src;
                    w.t_db = MEM;
                end
            end
            OP_JR, OP_JR_CC: begin
                if (s == 0) begin
                    fetch = 1'b0;
                    imm = 1'b1;
                end else if (s == 1) begin
                    fetch = 1'b0;       // Offset added to PCL
                    w.ab_mask = AB_MASK_AND_FF00;
                    w.idu = ADJ;
                    w.s_db = Z;
                    w.t_db = Z;
                    w.s_r_wb = R_WB_ALU;
                    w.alu_op = ADD;
                    w.s_acc = ACC_PCL;
                    w.s_rr_wb = RR_WB_IDU;
                end else if (s == 2) begin
                    w.s_ab = WZ;
                end
            end
            default: ;
        endcase
        if (imm) begin
            w.wr_pc = 1'b1;
            w.s_db = MEM;
            w.t_db = Z;
        end
        if (fetch) begin
            w.done = 1'b1;
            w.wr_pc = 1'b1;
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act,
                         input int beh);
        n_chk[beh]++;
        if (exp !== act) begin
            n_err[beh]++;
            errors++;
            $display("[FAIL] %s expected 0x%0h got 0x%0h (ir 0x%02h step %0d)",
                     name, exp, act, m_ir, m_step);
        end
    endtask

    always @(posedge clk) begin
        ctrl_word_t w;
        op_class_t  cls;
        int         beh;
        int         ctl;
        if (!rst) begin
            m_ir <= 8'h00;
            m_step <= '0;
            first <= 1'b1;
        end else begin
            cls = classify(m_ir);
            w = expected_word(m_ir, int'(m_step));
            beh = first ? 1 : 2;
            case (cls)
                OP_NOP: ctl = (m_ir == 8'h00) ? 3 : 6;
                OP_LD_R_R, OP_ALU_R, OP_INCDEC_R: ctl = 3;
                OP_JR, OP_JR_CC: ctl = 5;
                default: ctl = 4;
            endcase
            if (first) ctl = 1;
            check("ir", 16'(m_ir), 16'(ir), beh);
            check("step", 16'(m_step), 16'(step), beh);
            check("done", 16'(w.done), 16'(done), ctl);
            check("wr_pc", 16'(w.wr_pc), 16'(wr_pc), ctl);
            check("s_ab", 16'(w.s_ab), 16'(s_ab), ctl);
            check("ab_mask", 16'(w.ab_mask), 16'(ab_mask), ctl);
            check("s_db", 16'(w.s_db), 16'(s_db), ctl);
            check("t_db", 16'(w.t_db), 16'(t_db), ctl);
            check("s_r_wb", 16'(w.s_r_wb), 16'(s_r_wb), ctl);
            check("alu_op", 16'(w.alu_op), 16'(alu_op), ctl);
            check("s_acc", 16'(w.s_acc), 16'(s_acc), ctl);
            check("s_arg", 16'(w.s_arg), 16'(s_arg), ctl);
            check("idu", 16'(w.idu), 16'(idu), ctl);
            check("s_rr_wb", 16'(w.s_rr_wb), 16'(s_rr_wb), ctl);
            check("t_rr_wb", 16'(w.t_rr_wb), 16'(t_rr_wb), ctl);
            first <= 1'b0;
            if (w.done) begin
                m_ir <= d_in;           // Next opcode
                m_step <= '0;
            end else if (cls == OP_JR_CC && m_step == STEP_W'(0)
                         && !cond_true(m_ir[4:3], flags)) begin
                m_step <= STEP_W'(3);   // Branch not taken
            end else begin
                m_step <= m_step + STEP_W'(1);
            end
        end
    end

    task automatic report();
        int total_chk;
        int total_err;
        total_chk = 0;
        total_err = 0;
        for (int b = 1; b <= 6; b++) begin
            $display("behavior %0d %s: %0d checks, %0d errors",
                     b, beh_name[b], n_chk[b], n_err[b]);
            total_chk += n_chk[b];
            total_err += n_err[b];
        end
        $display("total: %0d checks, %0d errors", total_chk, total_err);
    endtask

endmodule

// ==== tb_cpu_ctrl.sv ====
module tb_cpu_ctrl;
    import cpu_ctrl_pkg::*;

    localparam int STEP_W = 3;
    localparam int RUN_CYCLES = 1000;

    logic              clk;
    logic              rst;
    logic [7:0]        d_in;
    flags_t            flags;
    logic [7:0]        ir;
    logic [STEP_W-1:0] step;
    logic              done;
    reg16_t            s_ab;
    ab_mask_t          ab_mask;
    reg8_t             s_db;
    reg8_t             t_db;
    s_r_wb_t           s_r_wb;
    alu_op_t           alu_op;
    s_acc_t            s_acc;
    s_arg_t            s_arg;
    idu_mode_t         idu;
    s_rr_wb_t          s_rr_wb;
    reg16_t            t_rr_wb;
    logic              wr_pc;
    int                errors;
    logic [15:0]       lfsr;
    logic              timed_out;

    cpu_ctrl #(.STEP_W(STEP_W)) UUT (.*);

    ctrl_checker #(.STEP_W(STEP_W)) chk (.*);

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic drive_inputs();
        logic [7:0] v;
        take_bits(8, v);
        d_in = v;
        take_bits(4, v);
        flags = flags_t'(v[3:0]);
    endtask

    task automatic wait_done(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = (done === 1'b1);
            n++;
        end
    endtask

    initial begin
        logic seen;
        clk = 1'b0;
        rst = 1'b0;
        d_in = 8'h00;
        flags = '0;
        lfsr = 16'd29;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        drive_inputs();
        wait_done(4, seen);
        if (!seen) begin
            $display("Timeout: done did not rise after reset");
            timed_out = 1'b1;
        end else begin
            for (int i = 0; i < RUN_CYCLES; i++) begin
                @(negedge clk);
                drive_inputs();
            end
            wait_done(8, seen);                 // Stop on an instruction boundary
            if (!seen) begin
                $display("Timeout: last instruction did not finish");
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        chk.report();
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
cpu_ctrl_pkg.sv
step_if.sv
field_if.sv
op_fields.sv
step_sequencer.sv
ucode_table.sv
cpu_ctrl.sv
ctrl_checker.sv
tb_cpu_ctrl.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_cpu_ctrl -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
